//--- logic/msoc_pkg.sv
// --------------------------------------------------
// shared widths, slot numbers, baud reset value
// and the UART state encodings
// --------------------------------------------------
package msoc_pkg;

  // bus side
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  slot_t;     // addr[23:20]
  typedef logic [3:0]  reg_idx_t;  // addr[5:2]

  // peripheral side
  typedef logic [7:0]  byte_t;
  typedef logic [10:0] baud_div_t; // clocks per serial bit
  typedef logic [15:0] led_t;
  typedef logic [7:0]  dip_t;

  // --------------------------------------------------
  // slot map
  // --------------------------------------------------
  localparam slot_t SLOT_UART = 4'd2;
  localparam slot_t SLOT_RXQ  = 4'd3;
  localparam slot_t SLOT_GPIO = 4'd7;

  localparam baud_div_t BAUD_RESET = 11'd54;

  typedef enum logic [1:0] {
    TX_IDLE, TX_START, TX_DATA, TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE, RX_START, RX_DATA, RX_STOP
  } rx_state_e;

endpackage

//--- logic/periph_regs.sv
// --------------------------------------------------
// bus write decode, LED/baud/DIP registers and the
// one-hot read-data mux
// --------------------------------------------------
`timescale 1ns/1ps

module periph_regs (
  input  logic                msoc_clk,
  input  logic                rstn,
  input  logic                bus_req_i,
  input  logic                bus_we_i,
  input  msoc_pkg::addr_t     bus_addr_i,
  input  msoc_pkg::word_t     bus_wdata_i,
  output msoc_pkg::word_t     bus_rdata_o,
  input  msoc_pkg::dip_t      dip_i,
  output msoc_pkg::led_t      leds_o,
  output logic                tx_start_o,
  output msoc_pkg::byte_t     tx_byte_o,
  output msoc_pkg::baud_div_t baud_div_o,
  output logic                rxq_pop_o,
  input  msoc_pkg::byte_t     rxq_byte_i,
  input  logic                rxq_err_i,
  input  logic                rxq_valid_i,
  input  logic                rxq_full_i,
  input  logic                rxq_ovf_i,
  input  logic                tx_busy_i,
  input  logic                rx_busy_i
);
  import msoc_pkg::*;

  slot_t    slot;
  reg_idx_t reg_idx;
  logic     wr_en;
  logic     [15:0] slot_sel;
  dip_t     dip_q;
  word_t    slot_rdata [16];

  assign slot    = bus_addr_i[23:20];
  assign reg_idx = bus_addr_i[5:2];
  assign wr_en   = bus_req_i & bus_we_i;

  // pop goes straight to the queue, taken at this edge
  assign rxq_pop_o = wr_en & slot_sel[SLOT_RXQ];

  // --------------------------------------------------
  // control registers
  // --------------------------------------------------
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      leds_o     <= '0;
      baud_div_o <= BAUD_RESET;
      tx_start_o <= 1'b0;
      dip_q      <= '0;
    end
    else
    begin
      dip_q      <= dip_i;             // one cycle of sync
      tx_start_o <= 1'b0;              // single-cycle pulse
      if (wr_en && slot_sel[SLOT_GPIO])
        leds_o <= bus_wdata_i[15:0];
      if (wr_en && slot_sel[SLOT_UART] && reg_idx == 4'd0)
        tx_start_o <= 1'b1;
      if (wr_en && slot_sel[SLOT_UART] && reg_idx == 4'd1)
        baud_div_o <= bus_wdata_i[10:0];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (wr_en && slot_sel[SLOT_UART] && reg_idx == 4'd0)
      tx_byte_o <= bus_wdata_i[7:0];   // held with the start pulse
  end

  // --------------------------------------------------
  // read side
  // --------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < 16; i++)
      slot_rdata[i] = '0;              // unmapped slots read zero
    slot_rdata[SLOT_UART] = (reg_idx == 4'd1) ? {21'b0, baud_div_o} : '0;
    slot_rdata[SLOT_RXQ]  = {18'b0, rx_busy_i, tx_busy_i, rxq_ovf_i, rxq_full_i,
                             rxq_valid_i, rxq_err_i, rxq_byte_i};
    slot_rdata[SLOT_GPIO] = {24'b0, dip_q};
  end

  always_comb
  begin
    bus_rdata_o = '0;
    for (int i = 0; i < 16; i++)
    begin
      slot_sel[i] = (slot == 4'(i));
      bus_rdata_o |= slot_sel[i] ? slot_rdata[i] : '0;
    end
  end

endmodule

//--- logic/uart_tx.sv
// --------------------------------------------------
// 8N1 serial transmitter
// --------------------------------------------------
`timescale 1ns/1ps

module uart_tx (
  input  logic                msoc_clk,
  input  logic                rstn,
  input  logic                tx_start_i,
  input  msoc_pkg::byte_t     tx_byte_i,
  input  msoc_pkg::baud_div_t baud_div_i,
  output logic                tx_o,
  output logic                busy_o
);
  import msoc_pkg::*;

  tx_state_e  state;
  baud_div_t  bit_cnt;
  baud_div_t  div_q;
  byte_t      shift_q;
  logic [2:0] bit_idx;
  logic       bit_end;
  logic       accept;

  assign accept  = (state == TX_IDLE) && tx_start_i; // start ignored while busy
  assign bit_end = (bit_cnt == div_q - 1'b1);
  assign busy_o  = (state != TX_IDLE);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state   <= TX_IDLE;
      tx_o    <= 1'b1;                 // line idles high
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      if (state != TX_IDLE)
        bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
      case (state)
        TX_IDLE:
        begin
          if (accept)
          begin
            state   <= TX_START;
            tx_o    <= 1'b0;           // start bit
            bit_cnt <= '0;
          end
        end
        TX_START:
        begin
          if (bit_end)
          begin
            state   <= TX_DATA;
            tx_o    <= shift_q[0];     // lsb first
            bit_idx <= '0;
          end
        end
        TX_DATA:
        begin
          if (bit_end && bit_idx == 3'd7)
          begin
            state <= TX_STOP;
            tx_o  <= 1'b1;
          end
          else if (bit_end)
          begin
            tx_o    <= shift_q[1];
            bit_idx <= bit_idx + 1'b1;
          end
        end
        TX_STOP:
        begin
          if (bit_end)
            state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (accept)
    begin
      div_q   <= baud_div_i;           // divisor fixed for the frame
      shift_q <= tx_byte_i;
    end
    else if (state == TX_DATA && bit_end)
      shift_q <= shift_q >> 1;
  end

endmodule

//--- logic/uart_rx.sv
// --------------------------------------------------
// rx majority filter and 8N1 serial receiver
// --------------------------------------------------
`timescale 1ns/1ps

module uart_rx (
  input  logic                msoc_clk,
  input  logic                rstn,
  input  logic                rx_i,
  input  msoc_pkg::baud_div_t baud_div_i,
  output logic                valid_o,
  output msoc_pkg::byte_t     byte_o,
  output logic                frame_err_o,
  output logic                busy_o
);
  import msoc_pkg::*;

  rx_state_e  state;
  logic [2:0] rx_sr;
  logic       line_maj;
  logic       line_q;
  logic       start_edge;
  baud_div_t  bit_cnt;
  baud_div_t  div_q;
  logic [2:0] bit_idx;
  logic       half_hit;
  logic       bit_end;

  // --------------------------------------------------
  // line filter
  // --------------------------------------------------
  assign line_maj = (rx_sr[0] & rx_sr[1]) | (rx_sr[0] & rx_sr[2]) | (rx_sr[1] & rx_sr[2]);

  assign start_edge = (state == RX_IDLE) && line_q && !line_maj;
  assign half_hit   = (bit_cnt == (div_q >> 1));   // middle of start bit
  assign bit_end    = (bit_cnt == div_q - 1'b1);   // one period on
  assign busy_o     = (state != RX_IDLE);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_sr       <= 3'b111;
      line_q      <= 1'b1;
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      bit_idx     <= '0;
      valid_o     <= 1'b0;
      frame_err_o <= 1'b0;
    end
    else
    begin
      rx_sr   <= {rx_sr[1:0], rx_i};
      line_q  <= line_maj;
      valid_o <= 1'b0;
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        RX_IDLE:
        begin
          bit_cnt <= '0;
          if (start_edge)
            state <= RX_START;
        end
        RX_START:
        begin
          if (half_hit)
          begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= line_maj ? RX_IDLE : RX_DATA;  // glitch, not a start
          end
        end
        RX_DATA:
        begin
          if (bit_end)
          begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= RX_STOP;
          end
        end
        RX_STOP:
        begin
          if (bit_end)
          begin
            valid_o     <= 1'b1;
            frame_err_o <= !line_maj;  // stop bit must be high
            state       <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (start_edge)
      div_q <= baud_div_i;
    if (state == RX_DATA && bit_end)
      byte_o <= {line_maj, byte_o[7:1]};  // lsb arrives first
  end

endmodule

//--- logic/rx_queue.sv
// --------------------------------------------------
// receive byte FIFO, first word fall through
// --------------------------------------------------
`timescale 1ns/1ps

module rx_queue #(
  parameter int unsigned RXQ_DEPTH_LOG2 = 4
) (
  input  logic            msoc_clk,
  input  logic            rstn,
  input  logic            push_i,
  input  msoc_pkg::byte_t push_byte_i,
  input  logic            push_err_i,
  input  logic            pop_i,
  output msoc_pkg::byte_t head_byte_o,
  output logic            head_err_o,
  output logic            valid_o,
  output logic            full_o,
  output logic            overflow_o
);

  localparam int unsigned DEPTH = 1 << RXQ_DEPTH_LOG2;

  logic [8:0]              mem [DEPTH];     // {frame err, byte}
  logic [RXQ_DEPTH_LOG2:0] wr_ptr;
  logic [RXQ_DEPTH_LOG2:0] rd_ptr;
  logic                    do_push;
  logic                    do_pop;
  logic [8:0]              head;

  assign valid_o = (wr_ptr != rd_ptr);
  assign full_o  = (wr_ptr[RXQ_DEPTH_LOG2] != rd_ptr[RXQ_DEPTH_LOG2]) &&
                   (wr_ptr[RXQ_DEPTH_LOG2-1:0] == rd_ptr[RXQ_DEPTH_LOG2-1:0]);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  // head reads zero while empty
  assign head        = valid_o ? mem[rd_ptr[RXQ_DEPTH_LOG2-1:0]] : '0;
  assign head_byte_o = head[7:0];
  assign head_err_o  = head[8];

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      overflow_o <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push_i && full_o)
        overflow_o <= 1'b1;            // sticky until reset
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      mem[wr_ptr[RXQ_DEPTH_LOG2-1:0]] <= {push_err_i, push_byte_i};
  end

endmodule

//--- logic/periph_top.sv
// --------------------------------------------------
// slow peripheral top: registers, UART, rx queue
// --------------------------------------------------
`timescale 1ns/1ps

module periph_top #(
  parameter int unsigned RXQ_DEPTH_LOG2 = 4
) (
  input  logic            msoc_clk,
  input  logic            rstn,
  input  logic            bus_req_i,
  input  logic            bus_we_i,
  input  msoc_pkg::addr_t bus_addr_i,
  input  msoc_pkg::word_t bus_wdata_i,
  output msoc_pkg::word_t bus_rdata_o,
  input  msoc_pkg::dip_t  dip_i,
  output msoc_pkg::led_t  leds_o,
  input  logic            uart_rx_i,
  output logic            uart_tx_o
);
  import msoc_pkg::*;

  logic      tx_start;
  byte_t     tx_byte;
  baud_div_t baud_div;
  logic      rxq_pop;
  logic      rx_valid;
  byte_t     rx_byte;
  logic      rx_frame_err;
  byte_t     rxq_byte;
  logic      rxq_err;
  logic      rxq_valid;
  logic      rxq_full;
  logic      rxq_ovf;
  logic      tx_busy;
  logic      rx_busy;

  periph_regs u_regs (
    .msoc_clk, .rstn, .bus_req_i, .bus_we_i, .bus_addr_i, .bus_wdata_i, .bus_rdata_o,
    .dip_i, .leds_o,
    .tx_start_o(tx_start), .tx_byte_o(tx_byte), .baud_div_o(baud_div), .rxq_pop_o(rxq_pop),
    .rxq_byte_i(rxq_byte), .rxq_err_i(rxq_err), .rxq_valid_i(rxq_valid),
    .rxq_full_i(rxq_full), .rxq_ovf_i(rxq_ovf), .tx_busy_i(tx_busy), .rx_busy_i(rx_busy)
  );

  uart_tx u_tx (
    .msoc_clk, .rstn, .tx_start_i(tx_start), .tx_byte_i(tx_byte),
    .baud_div_i(baud_div), .tx_o(uart_tx_o), .busy_o(tx_busy)
  );

  uart_rx u_rx (
    .msoc_clk, .rstn, .rx_i(uart_rx_i), .baud_div_i(baud_div), .valid_o(rx_valid),
    .byte_o(rx_byte), .frame_err_o(rx_frame_err), .busy_o(rx_busy)
  );

  rx_queue #(.RXQ_DEPTH_LOG2(RXQ_DEPTH_LOG2)) u_rxq (
    .msoc_clk, .rstn, .push_i(rx_valid), .push_byte_i(rx_byte), .push_err_i(rx_frame_err),
    .pop_i(rxq_pop), .head_byte_o(rxq_byte), .head_err_o(rxq_err), .valid_o(rxq_valid),
    .full_o(rxq_full), .overflow_o(rxq_ovf)
  );

endmodule

//--- verif/tb_clk.sv
// --------------------------------------------------
// testbench clock, 4 ns period, and reset
// --------------------------------------------------
`timescale 1ns/1ps

module tb_clk (
  output logic clk_o,
  output logic rstn_o
);

  initial
  begin
    clk_o  = 1'b0;
    rstn_o = 1'b0;
    repeat (2) @(negedge clk_o);    // two rising edges in reset
    rstn_o = 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

//--- verif/periph_assertions.sv
// --------------------------------------------------
// concurrent checks on the UART transmitter and the
// rx queue flags, attached by bind
// --------------------------------------------------
`timescale 1ns/1ps

module periph_assertions (
  input logic clk_i,
  input logic rstn_i,
  input logic tx_line_i,
  input logic tx_busy_i,
  input logic q_valid_i,
  input logic q_full_i,
  input logic q_ovf_i
);

  int fail_cnt = 0;                 // read back by the testbench

  tx_idle_high: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !tx_busy_i |-> tx_line_i)
  else
  begin
    fail_cnt++;
    $error("tx line low while the transmitter is idle");
  end

  full_not_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(q_full_i && !q_valid_i))
  else
  begin
    fail_cnt++;
    $error("queue full and empty at once");
  end

  ovf_sticky: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !$fell(q_ovf_i))
  else
  begin
    fail_cnt++;
    $error("overflow flag cleared outside reset");
  end

endmodule

// --------------------------------------------------
// attach points
// --------------------------------------------------
bind uart_tx periph_assertions u_tx_checks (
  .clk_i(msoc_clk), .rstn_i(rstn), .tx_line_i(tx_o), .tx_busy_i(busy_o),
  .q_valid_i(1'b0), .q_full_i(1'b0), .q_ovf_i(1'b0)
);

bind rx_queue periph_assertions u_q_checks (
  .clk_i(msoc_clk), .rstn_i(rstn), .tx_line_i(1'b1), .tx_busy_i(1'b0),
  .q_valid_i(valid_o), .q_full_i(full_o), .q_ovf_i(overflow_o)
);

//--- verif/periph_tb.sv
// --------------------------------------------------
// testbench for the peripheral block: bus stimulus,
// status reference model and UART loopback checks
// --------------------------------------------------
`timescale 1ns/1ps

module periph_tb;
  import msoc_pkg::*;

  localparam int RXQ_DEPTH_LOG2 = 4;
  localparam int RXQ_DEPTH      = 1 << RXQ_DEPTH_LOG2;
  localparam int WAIT_LIMIT     = 2000;  // cycles per wait

  logic  msoc_clk;
  logic  rstn;
  logic  bus_req;
  logic  bus_we;
  addr_t bus_addr;
  word_t bus_wdata;
  word_t bus_rdata;
  dip_t  dip;
  led_t  leds;
  logic  serial_line;                    // tx looped back into rx
  int    err_cnt;
  byte_t sent_q[$];                      // bytes expected in the rx queue
  logic  ovf_model;

  tb_clk u_clk (.clk_o(msoc_clk), .rstn_o(rstn));

  periph_top #(.RXQ_DEPTH_LOG2(RXQ_DEPTH_LOG2)) u_dut (
    .msoc_clk, .rstn, .bus_req_i(bus_req), .bus_we_i(bus_we), .bus_addr_i(bus_addr),
    .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata), .dip_i(dip), .leds_o(leds),
    .uart_rx_i(serial_line), .uart_tx_o(serial_line)
  );

  function automatic addr_t reg_addr(slot_t slot, reg_idx_t idx);
    return {8'h00, slot, 14'h0000, idx, 2'b00};
  endfunction

  // status word the queue model predicts, both UART halves idle
  function automatic word_t expected_status();
    word_t w;
    w = '0;
    if (sent_q.size() > 0)
    begin
      w[7:0] = sent_q[0];
      w[9]   = 1'b1;
    end
    w[10] = (sent_q.size() == RXQ_DEPTH);
    w[11] = ovf_model;
    return w;
  endfunction

  // line level k cycles into a frame at 8 cycles per bit
  function automatic logic frame_level(byte_t data, int k);
    if (k < 8)
      return 1'b0;
    if (k < 72)
      return data[(k - 8) / 8];
    return 1'b1;
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_led(string name, led_t exp, led_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_byte(string name, byte_t exp, byte_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------
  // bus access and queue model
  // --------------------------------------------------
  task automatic bus_write(addr_t addr, word_t data);
    @(negedge msoc_clk);
    bus_req   = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(negedge msoc_clk);
    bus_req = 1'b0;
    bus_we  = 1'b0;
  endtask

  task automatic bus_read(addr_t addr, output word_t data);
    @(negedge msoc_clk);
    bus_addr = addr;
    #1;
    data = bus_rdata;                    // combinational read, mid low phase
  endtask

  task automatic model_push(byte_t data);
    if (sent_q.size() < RXQ_DEPTH)
      sent_q.push_back(data);
    else
      ovf_model = 1'b1;                  // dropped by a full queue
  endtask

  task automatic wait_status(int pos, logic level, string what);
    word_t st;
    int    cycles;
    cycles = 0;
    do
    begin
      bus_read(reg_addr(SLOT_RXQ, 4'd0), st);
      cycles++;
    end
    while (st[pos] !== level && cycles < WAIT_LIMIT);
    if (st[pos] !== level)
    begin
      $display("timed out waiting for %s", what);
      err_cnt++;
    end
  endtask

  task automatic send_byte(byte_t data);
    bus_write(reg_addr(SLOT_UART, 4'd0), {24'h0, data});
    model_push(data);
    wait_status(12, 1'b1, "tx busy to rise");
    wait_status(12, 1'b0, "tx busy to fall");
  endtask

  // pop every queued byte, checking status and head against the model
  task automatic drain_queue(string name);
    word_t st;
    wait_status(13, 1'b0, "rx busy to fall");
    while (sent_q.size() > 0)
    begin
      wait_status(9, 1'b1, "queue valid");
      bus_read(reg_addr(SLOT_RXQ, 4'd0), st);
      check_word({name, " status"}, expected_status(), st);
      check_byte({name, " byte"}, sent_q[0], st[7:0]);
      bus_write(reg_addr(SLOT_RXQ, 4'd1), word_t'($urandom));
      void'(sent_q.pop_front());
    end
    bus_read(reg_addr(SLOT_RXQ, 4'd0), st);
    check_word({name, " empty"}, expected_status(), st);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    word_t rd;
    byte_t b;
    int    cycles;
    void'($urandom(32'h4253ce6c));
    err_cnt   = 0;
    ovf_model = 1'b0;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    dip       = '0;
    cycles    = 0;
    while (rstn !== 1'b1 && cycles < 20)
    begin
      @(posedge msoc_clk);
      cycles++;
    end
    if (rstn !== 1'b1)
    begin
      $display("reset was never released");
      err_cnt++;
    end
    @(negedge msoc_clk);

    check_led("reset leds", '0, leds);
    bus_read(reg_addr(SLOT_UART, 4'd1), rd);
    check_word("reset baud", 32'd54, rd);
    bus_read(reg_addr(SLOT_RXQ, 4'd0), rd);
    check_word("reset status", expected_status(), rd);
    bus_read(reg_addr(4'd5, 4'd0), rd);
    check_word("unmapped slot", '0, rd);

    repeat (4)
    begin
      rd = $urandom;
      bus_write(reg_addr(SLOT_GPIO, 4'd0), rd);
      check_led("led write", rd[15:0], leds);
    end
    @(negedge msoc_clk);
    dip = dip_t'($urandom);
    bus_read(reg_addr(SLOT_GPIO, 4'd0), rd);
    check_word("dip read", {24'h0, dip}, rd);

    // one frame at 8 cycles per bit, watched on the line
    bus_write(reg_addr(SLOT_UART, 4'd1), 32'd8);
    bus_read(reg_addr(SLOT_UART, 4'd1), rd);
    check_word("baud write", 32'd8, rd);
    b = byte_t'($urandom);
    bus_write(reg_addr(SLOT_UART, 4'd0), {24'h0, b});
    model_push(b);
    bus_addr = reg_addr(SLOT_RXQ, 4'd0);   // busy shows in bit 12
    cycles   = 0;
    do
    begin
      @(negedge msoc_clk);
      #1;
      cycles++;
    end
    while (serial_line !== 1'b0 && cycles < WAIT_LIMIT);
    if (serial_line !== 1'b0)
    begin
      $display("timed out waiting for the start bit");
      err_cnt++;
    end
    for (int k = 0; k <= 80; k++)
    begin
      if (k > 0)
      begin
        @(negedge msoc_clk);
        #1;
      end
      check_bit("tx line", frame_level(b, k), serial_line);
      check_bit("tx busy", (k < 80), bus_rdata[12]);
    end

    repeat (5) send_byte(byte_t'($urandom));
    drain_queue("loopback");

    repeat (RXQ_DEPTH + 1) send_byte(byte_t'($urandom));
    drain_queue("overflow");

    err_cnt += u_dut.u_tx.u_tx_checks.fail_cnt + u_dut.u_rxq.u_q_checks.fail_cnt;
    $display("failed checks: %0d", err_cnt);
    if (err_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    #200000;
    $display("simulation time limit reached before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
logic/msoc_pkg.sv
logic/periph_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/rx_queue.sv
logic/periph_top.sv
verif/tb_clk.sv
verif/periph_assertions.sv
verif/periph_tb.sv

//--- Makefile
# Verilator build and run of the peripheral testbench

SIM := obj_dir/Vperiph_tb

all: run

$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert --top-module periph_tb -f verilog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
